//--- build.f
+incdir+tests
design/sad_pkg.sv
design/sad_regs.sv
design/sad_window_control.sv
design/sad_lane.sv
design/sad_trigger.sv
design/sad_top.sv
tests/sad_tb.sv

//--- tests/sad_model.svh
`ifndef SAD_MODEL_SVH
`define SAD_MODEL_SVH

// cycles from a window's last sample on adc_data to its trigger pulse
localparam int TRIGGER_LATENCY = 6;

// run cycles needed up to the cycle before a pulse
// window end n >= REF_SAMPLES-1 and run held through n+5
localparam int FIRST_TRIGGER_RUN = REF_SAMPLES + TRIGGER_LATENCY - 1;

// sum of absolute differences between a window and the reference
function automatic int window_sad(input sample_t win [REF_SAMPLES],
                                  input sample_t ref_wave [REF_SAMPLES]);
    int sum;
    int a;
    int b;
    sum = 0;
    for (int p = 0; p < REF_SAMPLES; p++) begin
        a = int'(win[p]);
        b = int'(ref_wave[p]);
        sum += (a > b) ? a - b : b - a;
    end
    return sum;
endfunction

// trigger level in a cycle, from the previous cycle's run length and status
function automatic bit predict_trigger(input int run_len, input int sad, input int thr,
                                       input bit triggered, input bit multiple);
    if (run_len < FIRST_TRIGGER_RUN)
        return 1'b0;  // no full window yet, or disarmed
    if (triggered && !multiple)
        return 1'b0;  // single trigger already fired
    return (sad <= thr);
endfunction

// triggered flag after one edge
function automatic bit next_triggered(input bit triggered, input bit trig,
                                      input bit clear, input bit arm_edge);
    if (clear || arm_edge)
        return 1'b0;
    return trig ? 1'b1 : triggered;
endfunction

// sample at exactly delta away from the reference value
function automatic sample_t offset_sample(input sample_t r, input int delta);
    if (int'(r) + delta <= 2**SAMPLE_BITS - 1)
        return sample_t'(int'(r) + delta);
    return sample_t'(int'(r) - delta);
endfunction

`endif

//--- tests/sad_tb.sv
module sad_tb import sad_pkg::*; ();

    `include "sad_model.svh"

    // rough cycle budget per test, summed for the timeout
    localparam int TEST_CYCLES    = 200 + 200 + 300 + 600 + 250 + 250;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam int PATTERN_OFFSET = 2;  // per sample, for the boundary test

    logic       adc_sampleclk;
    logic       reset;
    sample_t    adc_data;
    logic       armed_and_ready;
    logic       active;
    reg_bus_t   reg_bus;
    logic [7:0] reg_data_in;
    logic [7:0] reg_data_out;
    logic       trigger;

    int      seed = 42;
    sample_t ref_wave [REF_SAMPLES];
    int      thr_model;
    bit      mult_model;
    bit      started;
    int      errors;
    int      checks;
    int      tests_run;
    int      errors_before;
    int      pulses;
    int      cycle_count;

    // compare process history
    sample_t sample_hist [TIMEOUT_CYCLES];
    int      mon_cycle;
    int      run_len_prev;
    bit      arm_prev;
    bit      arm_prev2;
    bit      wr_prev;
    bit      wr_prev2;
    bit      exp_prev;
    bit      triggered_prev;

    sad_top sad_top_inst (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_data        (adc_data),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_bus         (reg_bus),
        .reg_data_in     (reg_data_in),
        .reg_data_out    (reg_data_out),
        .trigger         (trigger)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #10 adc_sampleclk = ~adc_sampleclk;
    end

    always @(posedge adc_sampleclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // trigger checked mid-cycle against the model
    always @(negedge adc_sampleclk) begin : compare
        sample_t win [REF_SAMPLES];
        int      sad;
        bit      exp_now;
        bit      triggered_now;
        if (started) begin
            sample_hist[mon_cycle] = adc_data;
            sad = 0;
            if (run_len_prev >= FIRST_TRIGGER_RUN) begin
                for (int p = 0; p < REF_SAMPLES; p++)
                    win[p] = sample_hist[mon_cycle - FIRST_TRIGGER_RUN + p];
                sad = window_sad(win, ref_wave);
            end
            exp_now = predict_trigger(run_len_prev, sad, thr_model, triggered_prev, mult_model);
            check_value("trigger", exp_now, trigger);
            if (trigger === 1'b1)
                pulses++;
            triggered_now = next_triggered(triggered_prev, exp_prev, wr_prev2,
                                           arm_prev && !arm_prev2);
            run_len_prev   = (armed_and_ready && active) ? run_len_prev + 1 : 0;
            arm_prev2      = arm_prev;
            arm_prev       = armed_and_ready;
            wr_prev2       = wr_prev;
            wr_prev        = reg_bus.write && (reg_bus.address == ADDR_STATUS);
            exp_prev       = exp_now;
            triggered_prev = triggered_now;
            mon_cycle++;
        end
    end

    task automatic feed(input sample_t s);
        @(posedge adc_sampleclk);
        adc_data <= s;
    endtask

    task automatic feed_random(input int n);
        repeat (n) feed(sample_t'($random(seed)));
    endtask

    task automatic feed_pattern(input int delta);
        for (int p = 0; p < REF_SAMPLES; p++)
            feed(offset_sample(ref_wave[p], delta));
    endtask

    task automatic start_run();
        feed(sample_t'($random(seed)));  // this sample is index 0
        armed_and_ready <= 1'b1;
        active          <= 1'b1;
    endtask

    task automatic stop_run();
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        active          <= 1'b0;
        repeat (3) @(posedge adc_sampleclk);
    endtask

    task automatic reg_write(input logic [7:0] addr, input int cnt, input logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_bus     <= '{address: addr, bytecnt: BYTECNT_WIDTH'(cnt), read: 1'b0, write: 1'b1};
        reg_data_in <= data;
        @(posedge adc_sampleclk);
        reg_bus     <= '0;
        reg_data_in <= '0;
    endtask

    task automatic reg_read(input logic [7:0] addr, input int cnt, output logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_bus <= '{address: addr, bytecnt: BYTECNT_WIDTH'(cnt), read: 1'b1, write: 1'b0};
        @(negedge adc_sampleclk);
        data = reg_data_out;  // combinational read
        @(posedge adc_sampleclk);
        reg_bus <= '0;
    endtask

    task automatic set_threshold(input int value);
        reg_write(ADDR_THRESHOLD, 0, value[7:0]);
        reg_write(ADDR_THRESHOLD, 1, value[15:8]);
        thr_model = value;
    endtask

    task automatic set_multiple(input bit value);
        reg_write(ADDR_MULTIPLE_TRIGGERS, 0, {7'b0, value});
        mult_model = value;
    endtask

    task automatic check_status(input int exp_flag, input int exp_count);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        reg_read(ADDR_STATUS, 0, b0);
        reg_read(ADDR_STATUS, 1, b1);
        reg_read(ADDR_STATUS, 2, b2);
        check_value("status flag", exp_flag, b0);
        check_value("trigger count", exp_count, {b2, b1});
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
        tests_run++;
    endtask

    task automatic register_readback();
        logic [7:0] data;
        int         thr;
        for (int p = 0; p < REF_SAMPLES; p++) begin
            ref_wave[p] = sample_t'($random(seed));
            reg_write(ADDR_REFERENCE, p, ref_wave[p]);
        end
        thr = $random(seed) & 16'hffff;
        set_threshold(thr);
        set_multiple(1'b1);
        for (int p = 0; p < REF_SAMPLES; p++) begin
            reg_read(ADDR_REFERENCE, p, data);
            check_value("reference byte", ref_wave[p], data);
        end
        reg_read(ADDR_THRESHOLD, 0, data);
        check_value("threshold low", thr[7:0], data);
        reg_read(ADDR_THRESHOLD, 1, data);
        check_value("threshold high", thr[15:8], data);
        reg_read(ADDR_MULTIPLE_TRIGGERS, 0, data);
        check_value("multiple_triggers", 1, data);
        // nonzero register addressed, strobe low
        @(posedge adc_sampleclk);
        reg_bus <= '{address: ADDR_MULTIPLE_TRIGGERS, bytecnt: BYTECNT_WIDTH'(0),
                     read: 1'b0, write: 1'b0};
        @(negedge adc_sampleclk);
        check_value("reg_data_out idle", 0, reg_data_out);
        @(posedge adc_sampleclk);
        reg_bus <= '0;
        report_test("register readback");
    endtask

    task automatic exact_match();
        set_threshold(0);
        pulses = 0;
        start_run();
        feed_random(50);
        feed_pattern(0);
        feed_random(20);
        stop_run();
        check_value("trigger pulses", 1, pulses);
        report_test("exact match");
    endtask

    task automatic threshold_boundary();
        int d;
        d = REF_SAMPLES * PATTERN_OFFSET;  // total offset of the embedded window
        for (int pass = 0; pass < 2; pass++) begin
            set_threshold(d - 1 + pass);
            pulses = 0;
            start_run();
            feed_random(40);
            feed_pattern(PATTERN_OFFSET);
            feed_random(20);
            stop_run();
            check_value("trigger pulses", pass, pulses);
        end
        report_test("threshold boundary");
    endtask

    task automatic single_vs_multiple();
        set_threshold(0);
        for (int mode = 0; mode < 2; mode++) begin
            set_multiple(mode[0]);
            pulses = 0;
            start_run();  // arm edge clears earlier status
            repeat (3) begin
                feed_random(40);
                feed_pattern(0);
            end
            feed_random(20);
            stop_run();
            check_value("trigger pulses", mode ? 3 : 1, pulses);
            check_status(1, mode ? 3 : 1);
        end
        report_test("single vs multiple");
    endtask

    task automatic status_clear();
        reg_write(ADDR_STATUS, 0, 8'h00);
        check_status(0, 0);
        pulses = 0;
        start_run();
        feed_random(40);
        feed_pattern(0);
        feed_random(20);
        stop_run();
        check_status(1, 1);
        // rising arm edge with active low
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        repeat (2) @(posedge adc_sampleclk);
        check_status(0, 0);
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        report_test("status clear");
    endtask

    task automatic disarm_rearm();
        pulses = 0;
        start_run();
        feed_random(40);
        feed_pattern(0);
        feed_random(2);
        active <= 1'b0;  // before this window's trigger cycle
        feed_random(5);
        for (int p = 0; p < REF_SAMPLES; p++) begin
            feed(ref_wave[p]);
            if (p == 0)
                active <= 1'b1;  // new sample index 0
        end
        feed_random(20);
        stop_run();
        check_value("trigger pulses", 1, pulses);
        report_test("disarm");
    endtask

    initial begin
        reset           = 1'b1;
        adc_data        = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_bus         = '0;
        reg_data_in     = '0;
        repeat (3) @(posedge adc_sampleclk);
        reset   <= 1'b0;
        started = 1'b1;
        register_readback();
        exact_match();
        threshold_boundary();
        single_vs_multiple();
        status_clear();
        disarm_rearm();
        repeat (4) @(posedge adc_sampleclk);
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- design/sad_top.sv
module sad_top import sad_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  sample_t    adc_data,
    input  logic       armed_and_ready,
    input  logic       active,
    input  reg_bus_t   reg_bus,
    input  logic [7:0] reg_data_in,
    output logic [7:0] reg_data_out,
    output logic       trigger
);

    sad_t                   threshold;
    logic                   multiple_triggers;
    logic                   clear_status;
    logic                   triggered;
    logic [15:0]            num_triggers;
    logic [INDEX_WIDTH-1:0] ref_index;
    sample_t                ref_sample;
    sample_feed_t           sample_feed;
    logic [REF_SAMPLES-1:0] lane_restart;
    logic [REF_SAMPLES-1:0] lane_ready;
    logic [REF_SAMPLES-1:0] lane_match;
    logic                   arm_edge;

    // reference daisy chain, entry 0 fed by the register block
    sample_t ref_chain [REF_SAMPLES+1];

    assign ref_chain[0] = ref_sample;

    sad_regs regs_inst (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .reg_bus           (reg_bus),
        .reg_data_in       (reg_data_in),
        .reg_data_out      (reg_data_out),
        .ref_index         (ref_index),
        .ref_sample        (ref_sample),
        .threshold         (threshold),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

    sad_window_control control_inst (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .adc_data        (adc_data),
        .ref_index       (ref_index),
        .sample_feed     (sample_feed),
        .lane_restart    (lane_restart),
        .lane_ready      (lane_ready),
        .arm_edge        (arm_edge)
    );

    for (genvar i = 0; i < REF_SAMPLES; i++) begin : gen_lanes
        sad_lane lane_inst (
            .adc_sampleclk (adc_sampleclk),
            .ref_in        (ref_chain[i]),
            .ref_out       (ref_chain[i+1]),
            .sample_feed   (sample_feed),
            .restart       (lane_restart[i]),
            .ready         (lane_ready[i]),
            .threshold     (threshold),
            .match         (lane_match[i])
        );
    end

    sad_trigger trigger_inst (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .lane_match        (lane_match),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .arm_edge          (arm_edge),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

endmodule

//--- design/sad_trigger.sv
module sad_trigger import sad_pkg::*; (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic                   armed_and_ready,
    input  logic                   active,
    input  logic [REF_SAMPLES-1:0] lane_match,
    input  logic                   multiple_triggers,
    input  logic                   clear_status,
    input  logic                   arm_edge,
    output logic                   trigger,
    output logic                   triggered,
    output logic [15:0]            num_triggers
);

    logic any_match;
    logic hold_off;

    assign any_match = |lane_match;
    assign hold_off  = triggered && !multiple_triggers;  // single trigger mode

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !armed_and_ready || !active)
            trigger <= 1'b0;
        else
            trigger <= any_match && !hold_off;
    end

    // status, visible through the register block
    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_status || arm_edge) begin
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else if (trigger) begin
            triggered    <= 1'b1;
            num_triggers <= num_triggers + 1'b1;
        end
    end

endmodule

//--- design/sad_lane.sv
module sad_lane import sad_pkg::*; (
    input  logic         adc_sampleclk,
    input  sample_t      ref_in,
    output sample_t      ref_out,
    input  sample_feed_t sample_feed,
    input  logic         restart,
    input  logic         ready,
    input  sad_t         threshold,
    output logic         match
);

    sample_t ref_r;
    sad_t    ref_ext;
    logic    above;
    sad_t    incr;
    sad_t    acc;

    assign ref_ext = SAD_WIDTH'(ref_r);

    always_ff @(posedge adc_sampleclk) begin
        ref_out <= ref_in;   // daisy chain, one lane per cycle
        ref_r   <= ref_out;  // aligned with the extended sample

        // compare stage
        above <= (sample_feed.sample > ref_out);

        // absolute difference
        if (above)
            incr <= sample_feed.sample_ext - ref_ext;
        else
            incr <= sample_feed.sample_neg + ref_ext;

        // accumulate, hold once the msb sets
        if (restart)
            acc <= incr;
        else if (!acc[SAD_WIDTH-1])
            acc <= acc + incr;

        // acc holds a complete window on the restart cycle
        match <= restart && ready && (acc <= threshold);
    end

endmodule

//--- design/sad_window_control.sv
module sad_window_control import sad_pkg::*; (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic                   armed_and_ready,
    input  logic                   active,
    input  sample_t                adc_data,
    output logic [INDEX_WIDTH-1:0] ref_index,
    output sample_feed_t           sample_feed,
    output logic [REF_SAMPLES-1:0] lane_restart,
    output logic [REF_SAMPLES-1:0] lane_ready,
    output logic                   arm_edge
);

    logic arm_r;
    logic run;
    logic window_full;

    assign run         = armed_and_ready && active;
    assign window_full = (ref_index == INDEX_WIDTH'(REF_SAMPLES - 1));

    // rising edge of arm clears trigger status
    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            arm_r <= 1'b0;
        else
            arm_r <= armed_and_ready;
    end

    assign arm_edge = armed_and_ready && !arm_r;

    // index counter, restart ring and ready mask
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            ref_index    <= '0;
            lane_ready   <= '0;
            lane_restart <= RESTART_INIT;  // lane 0 loads as sample 0 reaches it
        end else begin
            ref_index    <= ref_index + 1'b1;  // wraps at REF_SAMPLES
            lane_restart <= {lane_restart[REF_SAMPLES-2:0], lane_restart[REF_SAMPLES-1]};
            // lane 0 ready after a full window, the rest follow one per cycle
            lane_ready   <= {lane_ready[REF_SAMPLES-2:0], lane_ready[0] | window_full};
        end
    end

    // sample broadcast pipeline
    always_ff @(posedge adc_sampleclk) begin
        sample_feed.sample     <= adc_data;
        sample_feed.sample_ext <= SAD_WIDTH'(sample_feed.sample);
        sample_feed.sample_neg <= -SAD_WIDTH'(sample_feed.sample);
    end

endmodule

//--- design/sad_regs.sv
module sad_regs import sad_pkg::*; (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  reg_bus_t               reg_bus,
    input  logic [7:0]             reg_data_in,
    output logic [7:0]             reg_data_out,
    input  logic [INDEX_WIDTH-1:0] ref_index,
    output sample_t                ref_sample,
    output sad_t                   threshold,
    output logic                   multiple_triggers,
    output logic                   clear_status,
    input  logic                   triggered,
    input  logic [15:0]            num_triggers
);

    sample_t ref_mem [REF_SAMPLES];

    logic [INDEX_WIDTH-1:0]  byte_index;
    logic                    ref_byte_ok;
    logic                    thr_byte_ok;
    logic                    status_byte_ok;
    logic [8*STATUS_BYTES-1:0] status_word;

    assign byte_index     = reg_bus.bytecnt[INDEX_WIDTH-1:0];
    assign ref_byte_ok    = (reg_bus.bytecnt < REF_SAMPLES);
    assign thr_byte_ok    = (reg_bus.bytecnt < SAD_WIDTH / 8);
    assign status_byte_ok = (reg_bus.bytecnt < STATUS_BYTES);

    // byte 0 flag, bytes 1-2 count low first
    assign status_word = {num_triggers, 7'b0, triggered};

    // sequencer fetch for lane 0
    assign ref_sample = ref_mem[ref_index];

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_mem           <= '{default: '0};
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            clear_status      <= 1'b0;
        end else begin
            clear_status <= reg_bus.write && (reg_bus.address == ADDR_STATUS);
            if (reg_bus.write) begin
                case (reg_bus.address)
                    ADDR_REFERENCE: begin
                        if (ref_byte_ok)
                            ref_mem[byte_index] <= reg_data_in;
                    end
                    ADDR_THRESHOLD: begin
                        if (thr_byte_ok)
                            threshold[8*reg_bus.bytecnt[0] +: 8] <= reg_data_in;
                    end
                    ADDR_MULTIPLE_TRIGGERS: multiple_triggers <= reg_data_in[0];
                    default: ;  // status write only makes the clear pulse
                endcase
            end
        end
    end

    always_comb begin
        reg_data_out = 8'h00;
        if (reg_bus.read) begin
            case (reg_bus.address)
                ADDR_REFERENCE: begin
                    if (ref_byte_ok)
                        reg_data_out = ref_mem[byte_index];
                end
                ADDR_THRESHOLD: begin
                    if (thr_byte_ok)
                        reg_data_out = threshold[8*reg_bus.bytecnt[0] +: 8];
                end
                ADDR_STATUS: begin
                    if (status_byte_ok)
                        reg_data_out = status_word[8*reg_bus.bytecnt[1:0] +: 8];
                end
                ADDR_MULTIPLE_TRIGGERS: reg_data_out = {7'b0, multiple_triggers};
                default: ;
            endcase
        end
    end

endmodule

//--- design/sad_pkg.sv
package sad_pkg;

    localparam int REF_SAMPLES   = 32;  // reference length, also number of lanes
    localparam int SAMPLE_BITS   = 8;
    localparam int SAD_WIDTH     = 16;  // msb doubles as saturation flag
    localparam int INDEX_WIDTH   = 5;
    localparam int BYTECNT_WIDTH = 7;

    // cycles from sample index 0 to the first accumulator load in lane 0
    localparam int RESTART_LEAD = 3;
    localparam logic [REF_SAMPLES-1:0] RESTART_INIT =
        {{(RESTART_LEAD-1){1'b0}}, 1'b1, {(REF_SAMPLES-RESTART_LEAD){1'b0}}};

    localparam int STATUS_BYTES = 3;

    // register map
    localparam logic [7:0] ADDR_REFERENCE         = 8'h30;
    localparam logic [7:0] ADDR_THRESHOLD         = 8'h31;
    localparam logic [7:0] ADDR_STATUS            = 8'h32;
    localparam logic [7:0] ADDR_MULTIPLE_TRIGGERS = 8'h33;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [SAD_WIDTH-1:0]   sad_t;

    // one register access, strobes valid for a single cycle
    typedef struct packed {
        logic [7:0]               address;
        logic [BYTECNT_WIDTH-1:0] bytecnt;
        logic                     read;
        logic                     write;
    } reg_bus_t;

    // sample as broadcast to every lane
    typedef struct packed {
        sample_t sample;      // input register stage
        sad_t    sample_ext;  // zero extended, one stage later
        sad_t    sample_neg;  // two's complement of sample_ext
    } sample_feed_t;

endpackage
